//--- Bender.yml
package:
  name: elevator_floor_control

sources:
  - floor_pkg.sv
  - request_if.sv
  - request_latch.sv
  - floor_scheduler.sv
  - car_command.sv
  - elevator_floor_control.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_elevator_floor_control.sv

//--- car_command.sv
// Car command register for run, direction, target floor and door permissions

`timescale 1ns/10ps

module car_command import floor_pkg::*; (
    input  logic   clock,
    input  logic   reset_n,
    input  floor_t target_floor,
    input  dir_t   travel_dir,
    input  logic   target_valid,
    input  floor_t current_floor,
    input  logic   car_moving,
    input  logic   power_on,
    input  logic   emergency,
    input  logic   door_open_button,
    input  logic   door_close_button,
    output logic   car_run,
    output logic   car_up,
    output floor_t car_target,
    output logic   door_open_ok,
    output logic   door_close_ok
);

    logic run_next;
    logic door_allowed;

    always_comb begin
        // Start only from standstill and only toward another floor
        run_next = target_valid && power_on && !emergency && !car_moving
                   && (target_floor != current_floor);

        // Doors answer only with the car stopped and power on
        door_allowed = !car_moving && power_on;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            car_run       <= 1'b0;
            car_up        <= 1'b0;
            car_target    <= '0;
            door_open_ok  <= 1'b0;
            door_close_ok <= 1'b0;
        end else begin
            car_run       <= run_next;
            car_up        <= (travel_dir == DIR_UP);
            car_target    <= target_floor;
            door_open_ok  <= door_open_button && door_allowed;
            door_close_ok <= door_close_button && door_allowed;
        end
    end

endmodule

//--- elevator_floor_control.f
floor_pkg.sv
request_if.sv
request_latch.sv
floor_scheduler.sv
car_command.sv
elevator_floor_control.sv
tb_clock_gen.sv
tb_elevator_floor_control.sv

//--- elevator_floor_control.sv
// Elevator floor controller top level with request latch, floor scheduler and car command

`timescale 1ns/10ps

module elevator_floor_control import floor_pkg::*; (
    input  logic        clock,
    input  logic        reset_n,
    input  floor_mask_t call_buttons,
    input  floor_mask_t panel_buttons,
    input  logic        door_open_button,
    input  logic        door_close_button,
    input  logic        emergency,
    input  logic        power_on,
    input  floor_t      current_floor,
    input  logic        car_moving,
    output floor_mask_t call_lights,
    output floor_mask_t panel_lights,
    output logic        car_run,
    output logic        car_up,
    output floor_t      car_target,
    output logic        door_open_ok,
    output logic        door_close_ok
);

    // Scheduler to car command
    floor_t target_floor;
    dir_t   travel_dir;
    logic   target_valid;

    request_if req_bus ();

    ////////////////////////////////////////////////////////////////////////////
    // Blocks
    ////////////////////////////////////////////////////////////////////////////

    request_latch u_request_latch (
        .clock         (clock),
        .reset_n       (reset_n),
        .call_buttons  (call_buttons),
        .panel_buttons (panel_buttons),
        .current_floor (current_floor),
        .power_on      (power_on),
        .emergency     (emergency),
        .req           (req_bus.latch)
    );

    floor_scheduler u_floor_scheduler (
        .clock         (clock),
        .reset_n       (reset_n),
        .req           (req_bus.sched),
        .current_floor (current_floor),
        .car_moving    (car_moving),
        .power_on      (power_on),
        .emergency     (emergency),
        .target_floor  (target_floor),
        .travel_dir    (travel_dir),
        .target_valid  (target_valid)
    );

    car_command u_car_command (
        .clock             (clock),
        .reset_n           (reset_n),
        .target_floor      (target_floor),
        .travel_dir        (travel_dir),
        .target_valid      (target_valid),
        .current_floor     (current_floor),
        .car_moving        (car_moving),
        .power_on          (power_on),
        .emergency         (emergency),
        .door_open_button  (door_open_button),
        .door_close_button (door_close_button),
        .car_run           (car_run),
        .car_up            (car_up),
        .car_target        (car_target),
        .door_open_ok      (door_open_ok),
        .door_close_ok     (door_close_ok)
    );

    // Lights go straight out to the buttons
    assign call_lights  = req_bus.call_lights;
    assign panel_lights = req_bus.panel_lights;

endmodule

//--- floor_pkg.sv
// Floor count and width constants, floor and mask types, direction and scheduler state enums

package floor_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Building size
    ////////////////////////////////////////////////////////////////////////////

    // Served floors, numbered 0 at the bottom
    localparam int NUM_FLOORS = 11;

    // Wide enough to hold the top floor number
    localparam int FLOOR_BITS = 4;

    ////////////////////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////////////////////

    // Floor number, 0 up to NUM_FLOORS-1
    typedef logic [FLOOR_BITS-1:0] floor_t;

    // One bit per floor, bit i is floor i
    typedef logic [NUM_FLOORS-1:0] floor_mask_t;

    // Travel direction of the car
    typedef enum logic {
        DIR_DOWN = 1'b0,
        DIR_UP   = 1'b1
    } dir_t;

    // Scheduler FSM states
    typedef enum logic [1:0] {
        SCHED_IDLE     = 2'd0,
        SCHED_DISPATCH = 2'd1,
        SCHED_TRAVEL   = 2'd2
    } sched_state_t;

endpackage

//--- floor_scheduler.sv
// Floor scheduler FSM with arrival detection, serve pulses and nearest-in-direction target search

`timescale 1ns/10ps

module floor_scheduler import floor_pkg::*; (
    input  logic     clock,
    input  logic     reset_n,
    request_if.sched req,
    input  floor_t   current_floor,
    input  logic     car_moving,
    input  logic     power_on,
    input  logic     emergency,
    output floor_t   target_floor,
    output dir_t     travel_dir,
    output logic     target_valid
);

    sched_state_t state;

    floor_mask_t lit;
    dir_t        back_dir;
    logic        hit_ahead;
    logic        hit_back;
    floor_t      pick_ahead;
    floor_t      pick_back;
    logic        ready;
    logic        arrived;

    // Nearest lit floor from the car in one direction, current floor counts as distance 0
    function automatic logic find_nearest(
        input  floor_mask_t mask,
        input  floor_t      from,
        input  dir_t        dir,
        output floor_t      pick
    );
        logic hit;
        int   idx;
        hit  = 1'b0;
        pick = from;
        for (int step = 0; step < NUM_FLOORS; step++) begin
            // Scan outward from the far end opposite to dir so the first hit is nearest
            idx = (dir == DIR_UP) ? step : NUM_FLOORS - 1 - step;
            if (!hit && mask[idx] && ((dir == DIR_UP) ? (idx >= from) : (idx <= from))) begin
                hit  = 1'b1;
                pick = floor_t'(idx);
            end
        end
        return hit;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Search and arrival
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        lit       = req.call_lights | req.panel_lights;
        back_dir  = (travel_dir == DIR_UP) ? DIR_DOWN : DIR_UP;
        hit_ahead = find_nearest(lit, current_floor, travel_dir, pick_ahead);
        hit_back  = find_nearest(lit, current_floor, back_dir, pick_back);

        // Wait out a serve pulse so the cleared lights are seen first
        ready   = !car_moving && power_on && !emergency && !req.serve;
        arrived = !car_moving && target_valid && (current_floor == target_floor);
    end

    // Target cannot change while serve is high
    assign req.serve_floor = target_floor;

    ////////////////////////////////////////////////////////////////////////////
    // Scheduler FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state        <= SCHED_IDLE;
            target_floor <= '0;
            travel_dir   <= DIR_UP;
            target_valid <= 1'b0;
            req.serve    <= 1'b0;
        end else begin
            req.serve <= 1'b0;
            case (state)
                SCHED_IDLE: begin
                    if (ready) begin
                        if (hit_ahead) begin
                            target_floor <= pick_ahead;
                            target_valid <= 1'b1;
                            state        <= SCHED_DISPATCH;
                        end else if (hit_back) begin
                            // Nothing ahead so turn around
                            target_floor <= pick_back;
                            travel_dir   <= back_dir;
                            target_valid <= 1'b1;
                            state        <= SCHED_DISPATCH;
                        end else begin
                            target_valid <= 1'b0;
                        end
                    end
                end
                // One cycle for the car command to pick up the new target
                SCHED_DISPATCH: begin
                    state <= SCHED_TRAVEL;
                end
                SCHED_TRAVEL: begin
                    if (arrived) begin
                        req.serve <= 1'b1;
                        state     <= SCHED_IDLE;
                    end
                end
                default: begin
                    state <= SCHED_IDLE;
                end
            endcase
        end
    end

endmodule

//--- request_if.sv
// Request bus between the light latch and the scheduler, with latch and sched modports

`timescale 1ns/10ps

interface request_if import floor_pkg::*; ();

    // Lit hall calls and lit car panel requests
    floor_mask_t call_lights;
    floor_mask_t panel_lights;

    // One-cycle pulse that clears both lights of serve_floor
    logic        serve;
    floor_t      serve_floor;

    modport latch (
        output call_lights,
        output panel_lights,
        input  serve,
        input  serve_floor
    );

    modport sched (
        input  call_lights,
        input  panel_lights,
        output serve,
        output serve_floor
    );

endinterface

//--- request_latch.sv
// Request latch holding the call and panel lights, set by buttons and cleared by serve pulses

`timescale 1ns/10ps

module request_latch import floor_pkg::*; (
    input  logic        clock,
    input  logic        reset_n,
    input  floor_mask_t call_buttons,
    input  floor_mask_t panel_buttons,
    input  floor_t      current_floor,
    input  logic        power_on,
    input  logic        emergency,
    request_if.latch    req
);

    // Floor the car is standing at
    floor_mask_t here_mask;
    // Floors a press may light this cycle
    floor_mask_t press_mask;
    // Floor being served this cycle
    floor_mask_t clear_mask;
    floor_mask_t call_next;
    floor_mask_t panel_next;

    // Lit floors stay lit, clearing beats a press of the same floor
    function automatic floor_mask_t update_lights(
        input floor_mask_t lights,
        input floor_mask_t buttons,
        input floor_mask_t allow,
        input floor_mask_t clear
    );
        return (lights | (buttons & allow)) & ~clear;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Set and clear masks
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        here_mask = floor_mask_t'(1) << current_floor;

        // Presses only count with power on and no emergency
        if (power_on && !emergency) begin
            press_mask = ~here_mask;
        end else begin
            press_mask = '0;
        end

        if (req.serve) begin
            clear_mask = floor_mask_t'(1) << req.serve_floor;
        end else begin
            clear_mask = '0;
        end

        call_next  = update_lights(req.call_lights, call_buttons, press_mask, clear_mask);
        panel_next = update_lights(req.panel_lights, panel_buttons, press_mask, clear_mask);
    end

    ////////////////////////////////////////////////////////////////////////////
    // Light registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            req.call_lights  <= '0;
            req.panel_lights <= '0;
        end else begin
            req.call_lights  <= call_next;
            req.panel_lights <= panel_next;
        end
    end

endmodule

//--- tb_clock_gen.sv
// Testbench clock and reset generator, 20 ns clock period and reset held low for 4 cycles

`timescale 1ns/10ps

module tb_clock_gen (
    output logic clock,
    output logic reset_n
);

    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 4;

    initial begin
        clock = 1'b0;
        forever begin
            #HALF_PERIOD;
            clock = ~clock;
        end
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;
    end

endmodule

//--- tb_elevator_floor_control.sv
// Testbench for the elevator floor controller with scenario table, car model and reference model

`timescale 1ns/10ps

module tb_elevator_floor_control import floor_pkg::*; ();

    localparam int NUM_ROWS    = 6;
    localparam int NUM_RANDOM  = 4;
    localparam int WAIT_CYCLES = 50;

    logic        clock;
    logic        reset_n;
    floor_mask_t call_buttons;
    floor_mask_t panel_buttons;
    logic        door_open_button;
    logic        door_close_button;
    logic        emergency;
    logic        power_on;
    floor_t      current_floor;
    logic        car_moving;
    floor_mask_t call_lights;
    floor_mask_t panel_lights;
    logic        car_run;
    logic        car_up;
    floor_t      car_target;
    logic        door_open_ok;
    logic        door_close_ok;

    // Scenario table with one entry per row
    floor_mask_t row_call [NUM_ROWS];
    floor_mask_t row_panel [NUM_ROWS];
    logic        row_power [NUM_ROWS];
    logic        row_emerg [NUM_ROWS];
    floor_t      row_floor [NUM_ROWS];
    logic        row_hold [NUM_ROWS];
    floor_mask_t row_exp_call [NUM_ROWS];
    floor_mask_t row_exp_panel [NUM_ROWS];

    // Reference model of the lights and travel direction
    floor_mask_t model_call;
    floor_mask_t model_panel;
    logic        model_up;
    integer      seed;
    logic [31:0] stim;

    tb_clock_gen clock_gen (
        .clock   (clock),
        .reset_n (reset_n)
    );

    elevator_floor_control dut0 (
        .clock             (clock),
        .reset_n           (reset_n),
        .call_buttons      (call_buttons),
        .panel_buttons     (panel_buttons),
        .door_open_button  (door_open_button),
        .door_close_button (door_close_button),
        .emergency         (emergency),
        .power_on          (power_on),
        .current_floor     (current_floor),
        .car_moving        (car_moving),
        .call_lights       (call_lights),
        .panel_lights      (panel_lights),
        .car_run           (car_run),
        .car_up            (car_up),
        .car_target        (car_target),
        .door_open_ok      (door_open_ok),
        .door_close_ok     (door_close_ok)
    );

    task automatic fail_run();
        $display("** FAIL **");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic set_row(input int idx, input floor_mask_t call, input floor_mask_t panel,
                           input logic power, input logic emerg, input floor_t floor,
                           input logic hold, input floor_mask_t exp_call,
                           input floor_mask_t exp_panel);
        row_call[idx]      = call;
        row_panel[idx]     = panel;
        row_power[idx]     = power;
        row_emerg[idx]     = emerg;
        row_floor[idx]     = floor;
        row_hold[idx]      = hold;
        row_exp_call[idx]  = exp_call;
        row_exp_panel[idx] = exp_panel;
    endtask

    // Tries distance 0 first and then one floor further each step
    function automatic logic nearest_lit(input floor_mask_t lit, input int from,
                                         input logic up, output int pick);
        int f;
        pick = from;
        for (int d = 0; d < NUM_FLOORS; d++) begin
            f = up ? from + d : from - d;
            if (f >= 0 && f < NUM_FLOORS && lit[f]) begin
                pick = f;
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic check_lights();
        assert (call_lights == model_call && panel_lights == model_panel) else begin
            $display("ERROR at %0t: lights call %h panel %h, expected call %h panel %h",
                     $time, call_lights, panel_lights, model_call, model_panel);
            fail_run();
        end
    endtask

    task automatic wait_for_reset();
        int cycles;
        cycles = 0;
        while (reset_n !== 1'b1 && cycles < WAIT_CYCLES) begin
            @(negedge clock);
            cycles++;
        end
        if (reset_n !== 1'b1) begin
            $display("Reset was never released by the clock generator");
            fail_run();
        end
    endtask

    task automatic wait_for_run();
        int cycles;
        cycles = 0;
        while (!car_run && cycles < WAIT_CYCLES) begin
            @(negedge clock);
            cycles++;
        end
        if (!car_run) begin
            $display("Timed out after %0d cycles waiting for car_run", WAIT_CYCLES);
            fail_run();
        end
    endtask

    task automatic wait_for_clear(input int floor);
        int cycles;
        cycles = 0;
        while ((call_lights[floor] || panel_lights[floor]) && cycles < WAIT_CYCLES) begin
            @(negedge clock);
            cycles++;
        end
        if (call_lights[floor] || panel_lights[floor]) begin
            $display("Timed out waiting for the lights of floor %0d to clear", floor);
            fail_run();
        end
    endtask

    // Plays the car moving one floor per cycle
    task automatic drive_car(input int target);
        int steps;
        steps = 0;
        car_moving = 1'b1;
        while (current_floor != target && steps < NUM_FLOORS) begin
            @(negedge clock);
            current_floor = (current_floor < target) ? current_floor + 1'b1 : current_floor - 1'b1;
            steps++;
            assert (!car_run) else begin
                $display("ERROR at %0t: car_run high while the car is moving", $time);
                fail_run();
            end
        end
        @(negedge clock);
        car_moving = 1'b0;
    endtask

    task automatic apply_presses(input floor_mask_t call, input floor_mask_t panel,
                                 input logic power, input logic emerg, input floor_t floor,
                                 input logic hold);
        floor_mask_t allow;
        allow = '0;
        if (power && !emerg) begin
            allow = ~(floor_mask_t'(1) << floor);
        end
        @(negedge clock);
        current_floor = floor;
        power_on      = power;
        emergency     = emerg;
        call_buttons  = call;
        panel_buttons = panel;
        model_call    = model_call | (call & allow);
        model_panel   = model_panel | (panel & allow);
        @(negedge clock);
        call_buttons  = '0;
        panel_buttons = '0;
        power_on      = 1'b1;
        emergency     = hold;
        check_lights();
        // Lit requests wait out the emergency
        for (int i = 0; i < 5 && hold; i++) begin
            @(negedge clock);
            assert (!car_run) else begin
                $display("ERROR at %0t: car_run high during emergency", $time);
                fail_run();
            end
            check_lights();
        end
        emergency = 1'b0;
    endtask

    task automatic serve_all();
        int   target;
        logic up;
        logic found;
        while ((model_call | model_panel) != '0) begin
            up    = model_up;
            found = nearest_lit(model_call | model_panel, current_floor, up, target);
            if (!found) begin
                up    = !model_up;
                found = nearest_lit(model_call | model_panel, current_floor, up, target);
            end
            wait_for_run();
            assert (car_target == target && car_up == up) else begin
                $display("ERROR at %0t: car_target %0d up %b, expected %0d up %b",
                         $time, car_target, car_up, target, up);
                fail_run();
            end
            model_up = up;
            drive_car(target);
            wait_for_clear(target);
            model_call[target]  = 1'b0;
            model_panel[target] = 1'b0;
            check_lights();
        end
        // Nothing left to serve
        for (int i = 0; i < 5; i++) begin
            @(negedge clock);
            assert (!car_run) else begin
                $display("ERROR at %0t: car_run high with no requests left", $time);
                fail_run();
            end
        end
    endtask

    task automatic check_doors();
        logic open_b;
        logic close_b;
        logic allowed;
        for (int i = 0; i < 24; i++) begin
            stim              = $random(seed);
            open_b            = stim[0];
            close_b           = stim[1];
            allowed           = !stim[2] && (stim[3] || stim[4]);
            door_open_button  = open_b;
            door_close_button = close_b;
            car_moving        = stim[2];
            power_on          = stim[3] || stim[4];
            @(negedge clock);
            assert (door_open_ok == (open_b && allowed)
                    && door_close_ok == (close_b && allowed)) else begin
                $display("ERROR at %0t: door ok open %b close %b, buttons %b %b allowed %b",
                         $time, door_open_ok, door_close_ok, open_b, close_b, allowed);
                fail_run();
            end
        end
        door_open_button  = 1'b0;
        door_close_button = 1'b0;
        car_moving        = 1'b0;
        power_on          = 1'b1;
        @(negedge clock);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        seed              = 32'hc130f591;
        call_buttons      = '0;
        panel_buttons     = '0;
        door_open_button  = 1'b0;
        door_close_button = 1'b0;
        emergency         = 1'b0;
        power_on          = 1'b1;
        current_floor     = '0;
        car_moving        = 1'b0;
        model_call        = '0;
        model_panel       = '0;
        model_up          = 1'b1;

        // call, panel, power, emergency, floor, hold, expected call, expected panel
        set_row(0, 11'h088, 11'h020, 1'b1, 1'b0, 4'd0, 1'b0, 11'h088, 11'h020);
        set_row(1, 11'h280, 11'h404, 1'b1, 1'b0, 4'd7, 1'b0, 11'h200, 11'h404);
        set_row(2, 11'h7ff, 11'h7ff, 1'b0, 1'b0, 4'd2, 1'b0, 11'h000, 11'h000);
        set_row(3, 11'h010, 11'h000, 1'b1, 1'b1, 4'd2, 1'b0, 11'h000, 11'h000);
        set_row(4, 11'h100, 11'h001, 1'b1, 1'b0, 4'd2, 1'b1, 11'h100, 11'h001);
        set_row(5, 11'h0a2, 11'h018, 1'b1, 1'b0, 4'd4, 1'b0, 11'h0a2, 11'h008);

        wait_for_reset();
        assert (call_lights == '0 && panel_lights == '0 && !car_run
                && !door_open_ok && !door_close_ok) else begin
            $display("ERROR at %0t: outputs not quiet after reset", $time);
            fail_run();
        end

        check_doors();

        for (int r = 0; r < NUM_ROWS; r++) begin
            apply_presses(row_call[r], row_panel[r], row_power[r], row_emerg[r],
                          row_floor[r], row_hold[r]);
            assert (call_lights == row_exp_call[r] && panel_lights == row_exp_panel[r]) else begin
                $display("ERROR at %0t: row %0d lights call %h panel %h, table %h %h",
                         $time, r, call_lights, panel_lights, row_exp_call[r], row_exp_panel[r]);
                fail_run();
            end
            serve_all();
        end

        // Extra press patterns
        for (int r = 0; r < NUM_RANDOM; r++) begin
            stim = $random(seed);
            apply_presses(stim[10:0], stim[21:11], 1'b1, 1'b0,
                          floor_t'(stim[31:22] % NUM_FLOORS), 1'b0);
            serve_all();
        end

        $display("** PASS **");
        $finish;
    end

endmodule
